// File: src/rename_pkg.sv
// ============================================================
// Rename package
// Register number types, opcode encoding and the sizes of the
// architectural and physical register files
// ============================================================
`default_nettype none

package rename_pkg;

	// Register file sizes
	localparam int AREGS = 16;
	localparam int PREGS = 32;

	localparam int AREG_W = $clog2(AREGS);
	localparam int PREG_W = $clog2(PREGS);

	// Physical registers with no mapping after reset
	// The upper part of the physical file starts out free
	localparam int FREE_AT_RESET = PREGS - AREGS;

	// Register numbers
	typedef logic [AREG_W-1:0] areg_t;
	typedef logic [PREG_W-1:0] preg_t;

	// Opcodes, top nibble of the instruction word
	typedef enum logic [3:0] {
		OP_NOP    = 4'h0,
		OP_ALU    = 4'h1,
		OP_ALUI   = 4'h2,
		OP_LOAD   = 4'h3,
		OP_STORE  = 4'h4,
		OP_BRANCH = 4'h5
	} op_e;

endpackage

`default_nettype wire

// File: src/instr_decoder.sv
// ============================================================
// Instruction decoder
// Splits the 16-bit word into opcode and register fields and
// flags which register fields the opcode actually uses
// ============================================================
`timescale 1ns/100ps
`default_nettype none

module instr_decoder (
	input  logic [15:0]        instr,
	output rename_pkg::op_e    op,
	output rename_pkg::areg_t  rd,
	output rename_pkg::areg_t  rs1,
	output rename_pkg::areg_t  rs2,
	output logic               dst_used,
	output logic               src1_used,
	output logic               src2_used,
	output logic               is_branch
);
	import rename_pkg::*;

	// Word layout: op[15:12] rd[11:8] rs1[7:4] rs2[3:0]
	assign rd  = instr[11:8];
	assign rs1 = instr[7:4];
	assign rs2 = instr[3:0];

	// Opcode table
	// Unknown encodings fall back to a NOP with no register use
	always_comb begin
		op        = OP_NOP;
		dst_used  = 1'b0;
		src1_used = 1'b0;
		src2_used = 1'b0;
		case (instr[15:12])
			OP_ALU: begin
				op        = OP_ALU;
				dst_used  = 1'b1;
				src1_used = 1'b1;
				src2_used = 1'b1;
			end
			OP_ALUI, OP_LOAD: begin
				// Immediate forms only read source 1
				op        = op_e'(instr[15:12]);
				dst_used  = 1'b1;
				src1_used = 1'b1;
			end
			OP_STORE, OP_BRANCH: begin
				op        = op_e'(instr[15:12]);
				src1_used = 1'b1;
				src2_used = 1'b1;
			end
			default: begin
				op = OP_NOP;
			end
		endcase
	end

	assign is_branch = (op == OP_BRANCH);

endmodule

`default_nettype wire

// File: src/checkpoint_ram.sv
// ============================================================
// Checkpoint RAM
// One full alias map snapshot per branch checkpoint
// Synchronous write, registered read like a block RAM
// ============================================================
`timescale 1ns/100ps
`default_nettype none

module checkpoint_ram #(
	parameter int CHECKPOINTS = 8
) (
	input  logic                                    clk,
	input  logic                                    wr_en,
	input  logic [$clog2(CHECKPOINTS)-1:0]          wr_addr,
	input  rename_pkg::preg_t [rename_pkg::AREGS-1:0] wr_map,
	input  logic [$clog2(CHECKPOINTS)-1:0]          rd_addr,
	output rename_pkg::preg_t [rename_pkg::AREGS-1:0] rd_map
);
	import rename_pkg::*;

	// Snapshot storage, one map per slot
	preg_t [AREGS-1:0] mem [CHECKPOINTS];

	// Write port
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_map;
		end
	end

	// Read port, data shows one cycle after the address
	always_ff @(posedge clk) begin
		rd_map <= mem[rd_addr];
	end

endmodule

`default_nettype wire

// File: src/reg_alias_table.sv
// ============================================================
// Register alias table
// Current arch to phys map, circular branch checkpoints,
// stall generation and per-checkpoint allocation tracking
// used to hand wrong-path registers back on a restore
// ============================================================
`timescale 1ns/100ps
`default_nettype none

module reg_alias_table #(
	parameter int CHECKPOINTS = 8
) (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           rename,
	input  logic                           is_branch,
	input  logic                           dst_used,
	input  logic                           src1_used,
	input  logic                           src2_used,
	input  rename_pkg::areg_t              rd,
	input  rename_pkg::areg_t              rs1,
	input  rename_pkg::areg_t              rs2,
	input  logic                           free_avail,
	input  rename_pkg::preg_t              alloc_preg,
	input  logic                           cmt_branch,
	input  logic                           restore,
	input  logic [$clog2(CHECKPOINTS)-1:0] restore_cp,
	output logic                           alloc_take,
	output rename_pkg::preg_t              ps1,
	output rename_pkg::preg_t              ps2,
	output rename_pkg::preg_t              prd,
	output rename_pkg::preg_t              old_prd,
	output logic [$clog2(CHECKPOINTS)-1:0] cp,
	output logic                           stall,
	output logic [rename_pkg::PREGS-1:0]   restore_free
);
	import rename_pkg::*;

	localparam int CPW = $clog2(CHECKPOINTS);

	// ============================================================
	// State
	// ============================================================
	preg_t [AREGS-1:0] map;
	preg_t [AREGS-1:0] next_map;
	preg_t [AREGS-1:0] snap_map;

	// Head and tail carry a wrap bit so full and empty differ
	logic [CPW:0]       cp_head;
	logic [CPW:0]       cp_tail;
	logic [CPW:0]       cp_count;
	logic               restore_pend;

	// Registers allocated since each checkpoint was taken
	logic [PREGS-1:0]       since [CHECKPOINTS];
	logic [PREGS-1:0]       alloc_mask;
	logic [CHECKPOINTS-1:0] cp_open;
	logic                   take_branch;
	logic [CPW-1:0]         restore_dist;

	checkpoint_ram #(
		.CHECKPOINTS(CHECKPOINTS)
	) checkpoint_ram_inst (
		.clk    (clk),
		.wr_en  (take_branch),
		.wr_addr(cp_tail[CPW-1:0]),
		.wr_map (next_map),
		.rd_addr(restore_cp),
		.rd_map (snap_map)
	);

	// ============================================================
	// Lookup and allocation
	// ============================================================
	assign alloc_take  = rename & dst_used;
	assign take_branch = rename & is_branch;

	// Sources read straight from the live map
	// Unused sources report register 0
	assign ps1     = src1_used ? map[rs1] : '0;
	assign ps2     = src2_used ? map[rs2] : '0;
	assign prd     = alloc_preg;
	assign old_prd = map[rd];
	assign cp      = cp_tail[CPW-1:0];

	// Map as it stands after this cycle's rename, for the snapshot
	always_comb begin
		next_map = map;
		if (alloc_take) begin
			next_map[rd] = alloc_preg;
		end
	end

	assign alloc_mask = alloc_take ? ({{(PREGS-1){1'b0}}, 1'b1} << alloc_preg) : '0;

	// Outstanding checkpoints
	assign cp_count = cp_tail - cp_head;

	// A slot is open when it lies between head and tail
	always_comb begin
		logic [CPW-1:0] offs;
		for (int i = 0; i < CHECKPOINTS; i++) begin
			offs       = CPW'(i) - cp_head[CPW-1:0];
			cp_open[i] = ({1'b0, offs} < cp_count);
		end
	end

	// Out of registers, out of checkpoints, or map reload in flight
	assign stall = ~free_avail | (cp_count == (CPW+1)'(CHECKPOINTS)) | restore_pend;

	// Wrong-path registers go back in the restore cycle
	assign restore_free = restore ? since[restore_cp] : '0;

	// Distance from head to the restored slot
	assign restore_dist = restore_cp - cp_head[CPW-1:0];

	// ============================================================
	// Sequential update
	// ============================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < AREGS; i++) begin
				map[i] <= preg_t'(i);
			end
		end else if (restore_pend) begin
			// Snapshot arrives from the RAM one cycle after restore
			map <= snap_map;
		end else begin
			map <= next_map;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			cp_head      <= '0;
			cp_tail      <= '0;
			restore_pend <= 1'b0;
		end else begin
			restore_pend <= restore;
			if (cmt_branch && cp_count != '0) begin
				cp_head <= cp_head + 1'b1;
			end
			// The restored branch stays outstanding, younger ones drop
			if (restore) begin
				cp_tail <= cp_head + (CPW+1)'(restore_dist) + (CPW+1)'(1);
			end else if (take_branch) begin
				cp_tail <= cp_tail + 1'b1;
			end
		end
	end

	// Allocation tracking per checkpoint
	always_ff @(posedge clk) begin
		for (int i = 0; i < CHECKPOINTS; i++) begin
			if (rst) begin
				since[i] <= '0;
			end else if (take_branch && cp_tail[CPW-1:0] == CPW'(i)) begin
				// Fresh slot starts with nothing allocated
				since[i] <= '0;
			end else if (restore && restore_cp == CPW'(i)) begin
				since[i] <= '0;
			end else if (cp_open[i]) begin
				since[i] <= since[i] | alloc_mask;
			end
		end
	end

endmodule

`default_nettype wire

// File: src/free_list.sv
// ============================================================
// Free list
// Bit vector of free physical registers
// Hands out the lowest-numbered free register first
// ============================================================
`timescale 1ns/100ps
`default_nettype none

module free_list (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         alloc_take,
	input  logic                         release_valid,
	input  rename_pkg::preg_t            release_preg,
	input  logic [rename_pkg::PREGS-1:0] restore_free,
	output logic                         free_avail,
	output rename_pkg::preg_t            alloc_preg
);
	import rename_pkg::*;

	logic [PREGS-1:0] free_vec;
	logic [PREGS-1:0] take_mask;
	logic [PREGS-1:0] rel_mask;

	// Lowest set bit wins, scan from the top down
	always_comb begin
		alloc_preg = '0;
		for (int i = PREGS - 1; i >= 0; i--) begin
			if (free_vec[i]) begin
				alloc_preg = preg_t'(i);
			end
		end
	end

	assign free_avail = |free_vec;

	assign take_mask = alloc_take ? ({{(PREGS-1){1'b0}}, 1'b1} << alloc_preg) : '0;
	assign rel_mask  = release_valid ? ({{(PREGS-1){1'b0}}, 1'b1} << release_preg) : '0;

	// Take, release, then bulk return from a branch miss
	always_ff @(posedge clk) begin
		if (rst) begin
			// Registers above the identity map start free
			free_vec <= {{FREE_AT_RESET{1'b1}}, {AREGS{1'b0}}};
		end else begin
			free_vec <= (free_vec & ~take_mask) | rel_mask | restore_free;
		end
	end

endmodule

`default_nettype wire

// File: src/rename_result.sv
// ============================================================
// Rename result stage
// Holds the renamed instruction for one cycle with its strobe
// ============================================================
`timescale 1ns/100ps
`default_nettype none

module rename_result #(
	parameter int CHECKPOINTS = 8
) (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           rename,
	input  rename_pkg::op_e                op,
	input  rename_pkg::preg_t              prd,
	input  rename_pkg::preg_t              old_prd,
	input  rename_pkg::preg_t              ps1,
	input  rename_pkg::preg_t              ps2,
	input  logic                           dst_used,
	input  logic                           src1_used,
	input  logic                           src2_used,
	input  logic [$clog2(CHECKPOINTS)-1:0] cp,
	output logic                           out_valid,
	output rename_pkg::op_e                out_op,
	output rename_pkg::preg_t              out_prd,
	output rename_pkg::preg_t              out_old_prd,
	output rename_pkg::preg_t              out_ps1,
	output rename_pkg::preg_t              out_ps2,
	output logic                           out_dst_used,
	output logic                           out_src1_used,
	output logic                           out_src2_used,
	output logic [$clog2(CHECKPOINTS)-1:0] out_cp
);
	import rename_pkg::*;

	// Strobe, one cycle per rename
	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= rename;
		end
	end

	// Payload only loads on a rename
	always_ff @(posedge clk) begin
		if (rename) begin
			out_op        <= op;
			out_prd       <= prd;
			out_old_prd   <= old_prd;
			out_ps1       <= ps1;
			out_ps2       <= ps2;
			out_dst_used  <= dst_used;
			out_src1_used <= src1_used;
			out_src2_used <= src2_used;
			out_cp        <= cp;
		end
	end

endmodule

`default_nettype wire

// File: src/rename_unit.sv
// ============================================================
// Register rename unit
// One instruction per cycle: decode, map lookup, allocation,
// branch checkpoints and restore on a branch miss
// ============================================================
`timescale 1ns/100ps
`default_nettype none

module rename_unit #(
	parameter int CHECKPOINTS = 8
) (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           instr_valid,
	input  logic [15:0]                    instr,
	input  logic                           cmt_valid,
	input  rename_pkg::preg_t              cmt_old_preg,
	input  logic                           cmt_branch,
	input  logic                           restore,
	input  logic [$clog2(CHECKPOINTS)-1:0] restore_cp,
	output logic                           stall,
	output logic                           out_valid,
	output rename_pkg::op_e                out_op,
	output rename_pkg::preg_t              out_prd,
	output rename_pkg::preg_t              out_old_prd,
	output rename_pkg::preg_t              out_ps1,
	output rename_pkg::preg_t              out_ps2,
	output logic                           out_dst_used,
	output logic                           out_src1_used,
	output logic                           out_src2_used,
	output logic [$clog2(CHECKPOINTS)-1:0] out_cp
);
	import rename_pkg::*;

	// Decoded fields
	op_e   op;
	areg_t rd;
	areg_t rs1;
	areg_t rs2;
	logic  dst_used;
	logic  src1_used;
	logic  src2_used;
	logic  is_branch;

	// Table and free list handshake
	logic             free_avail;
	preg_t            alloc_preg;
	logic             alloc_take;
	logic [PREGS-1:0] restore_free;

	// Renamed operands
	preg_t                           ps1;
	preg_t                           ps2;
	preg_t                           prd;
	preg_t                           old_prd;
	logic [$clog2(CHECKPOINTS)-1:0]  cp;

	instr_decoder instr_decoder_inst (
		.instr    (instr),
		.op       (op),
		.rd       (rd),
		.rs1      (rs1),
		.rs2      (rs2),
		.dst_used (dst_used),
		.src1_used(src1_used),
		.src2_used(src2_used),
		.is_branch(is_branch)
	);

	reg_alias_table #(
		.CHECKPOINTS(CHECKPOINTS)
	) reg_alias_table_inst (
		.clk         (clk),
		.rst         (rst),
		.rename      (instr_valid),
		.is_branch   (is_branch),
		.dst_used    (dst_used),
		.src1_used   (src1_used),
		.src2_used   (src2_used),
		.rd          (rd),
		.rs1         (rs1),
		.rs2         (rs2),
		.free_avail  (free_avail),
		.alloc_preg  (alloc_preg),
		.cmt_branch  (cmt_branch),
		.restore     (restore),
		.restore_cp  (restore_cp),
		.alloc_take  (alloc_take),
		.ps1         (ps1),
		.ps2         (ps2),
		.prd         (prd),
		.old_prd     (old_prd),
		.cp          (cp),
		.stall       (stall),
		.restore_free(restore_free)
	);

	// Commit hands the replaced mapping back
	free_list free_list_inst (
		.clk          (clk),
		.rst          (rst),
		.alloc_take   (alloc_take),
		.release_valid(cmt_valid),
		.release_preg (cmt_old_preg),
		.restore_free (restore_free),
		.free_avail   (free_avail),
		.alloc_preg   (alloc_preg)
	);

	rename_result #(
		.CHECKPOINTS(CHECKPOINTS)
	) rename_result_inst (
		.clk          (clk),
		.rst          (rst),
		.rename       (instr_valid),
		.op           (op),
		.prd          (prd),
		.old_prd      (old_prd),
		.ps1          (ps1),
		.ps2          (ps2),
		.dst_used     (dst_used),
		.src1_used    (src1_used),
		.src2_used    (src2_used),
		.cp           (cp),
		.out_valid    (out_valid),
		.out_op       (out_op),
		.out_prd      (out_prd),
		.out_old_prd  (out_old_prd),
		.out_ps1      (out_ps1),
		.out_ps2      (out_ps2),
		.out_dst_used (out_dst_used),
		.out_src1_used(out_src1_used),
		.out_src2_used(out_src2_used),
		.out_cp       (out_cp)
	);

endmodule

`default_nettype wire

// File: bench/rename_checker.sv
// ============================================================
// Rename checker
// Compares the DUT outputs one cycle after each case line
// and counts value and strobe errors
// ============================================================
`timescale 1ns/100ps
`default_nettype none

module rename_checker #(
	parameter int CHECKPOINTS = 8
) (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           check_on,
	input  logic                           exp_valid,
	input  logic [3:0]                     exp_op,
	input  rename_pkg::preg_t              exp_prd,
	input  rename_pkg::preg_t              exp_old_prd,
	input  rename_pkg::preg_t              exp_ps1,
	input  rename_pkg::preg_t              exp_ps2,
	input  logic                           exp_dst_used,
	input  logic                           exp_src1_used,
	input  logic                           exp_src2_used,
	input  logic [$clog2(CHECKPOINTS)-1:0] exp_cp,
	input  logic                           exp_stall,
	input  logic                           stall,
	input  logic                           out_valid,
	input  rename_pkg::op_e                out_op,
	input  rename_pkg::preg_t              out_prd,
	input  rename_pkg::preg_t              out_old_prd,
	input  rename_pkg::preg_t              out_ps1,
	input  rename_pkg::preg_t              out_ps2,
	input  logic                           out_dst_used,
	input  logic                           out_src1_used,
	input  logic                           out_src2_used,
	input  logic [$clog2(CHECKPOINTS)-1:0] out_cp,
	output int                             value_errors,
	output int                             strobe_errors
);
	import rename_pkg::*;

	localparam int CPW = $clog2(CHECKPOINTS);

	// Expectations of the previous case line, due in this cycle
	logic           pend_on;
	logic           pend_valid;
	logic [3:0]     pend_op;
	preg_t          pend_prd;
	preg_t          pend_old_prd;
	preg_t          pend_ps1;
	preg_t          pend_ps2;
	logic           pend_dst_used;
	logic           pend_src1_used;
	logic           pend_src2_used;
	logic [CPW-1:0] pend_cp;
	logic           pend_stall;

	int value_count = 0;
	int strobe_count = 0;

	assign value_errors  = value_count;
	assign strobe_errors = strobe_count;

	// One field against its expected value
	task automatic compare_value(input string name, input logic [15:0] got,
			input logic [15:0] want);
		if (got !== want) begin
			value_count = value_count + 1;
			$display("[FAIL] %s: got 0x%0h, expected 0x%0h at %0t ns", name, got, want, $time);
		end
	endtask

	// ============================================================
	// Per-cycle comparison
	// ============================================================
	task automatic compare_cycle();
		if (pend_valid && !out_valid) begin
			strobe_count = strobe_count + 1;
			$display("Missing out_valid at %0t ns, a renamed instruction was due", $time);
		end else if (!pend_valid && out_valid) begin
			strobe_count = strobe_count + 1;
			$display("Unexpected out_valid at %0t ns, no instruction was strobed", $time);
		end else if (pend_valid) begin
			compare_value("out_op", 16'(out_op), 16'(pend_op));
			compare_value("out_dst_used", 16'(out_dst_used), 16'(pend_dst_used));
			compare_value("out_src1_used", 16'(out_src1_used), 16'(pend_src1_used));
			compare_value("out_src2_used", 16'(out_src2_used), 16'(pend_src2_used));
			compare_value("out_cp", 16'(out_cp), 16'(pend_cp));
			// Destination fields only mean something when a register was taken
			if (pend_dst_used) begin
				compare_value("out_prd", 16'(out_prd), 16'(pend_prd));
				compare_value("out_old_prd", 16'(out_old_prd), 16'(pend_old_prd));
			end
			if (pend_src1_used) begin
				compare_value("out_ps1", 16'(out_ps1), 16'(pend_ps1));
			end
			if (pend_src2_used) begin
				compare_value("out_ps2", 16'(out_ps2), 16'(pend_ps2));
			end
		end
		// Stall reflects the state left by the previous line
		compare_value("stall", 16'(stall), 16'(pend_stall));
	endtask

	always @(posedge clk) begin
		if (rst) begin
			pend_on <= 1'b0;
		end else begin
			if (pend_on) begin
				compare_cycle();
			end
			pend_on        <= check_on;
			pend_valid     <= exp_valid;
			pend_op        <= exp_op;
			pend_prd       <= exp_prd;
			pend_old_prd   <= exp_old_prd;
			pend_ps1       <= exp_ps1;
			pend_ps2       <= exp_ps2;
			pend_dst_used  <= exp_dst_used;
			pend_src1_used <= exp_src1_used;
			pend_src2_used <= exp_src2_used;
			pend_cp        <= exp_cp;
			pend_stall     <= exp_stall;
		end
	end

endmodule

`default_nettype wire

// File: bench/rename_unit_sva.sv
// ============================================================
// Rename unit assertions
// Producer rules on the input strobes, one-cycle output
// strobe, and legal destinations before any commit
// ============================================================
`timescale 1ns/100ps
`default_nettype none

module rename_unit_sva (
	input  logic              clk,
	input  logic              rst,
	input  logic              instr_valid,
	input  logic              restore,
	input  logic              cmt_valid,
	input  logic              stall,
	input  logic              out_valid,
	input  logic              out_dst_used,
	input  rename_pkg::preg_t out_prd
);
	import rename_pkg::*;

	int stall_errors = 0;
	int overlap_errors = 0;
	int strobe_errors = 0;
	int low_prd_errors = 0;
	int fail_count;

	// Set by the first commit, from then on low registers may come back
	logic committed;

	assign fail_count = stall_errors + overlap_errors + strobe_errors + low_prd_errors;

	always_ff @(posedge clk) begin
		if (rst) begin
			committed <= 1'b0;
		end else if (cmt_valid) begin
			committed <= 1'b1;
		end
	end

	// Producer must hold off while stalled
	assert property (@(posedge clk) disable iff (rst) instr_valid |-> !stall)
		else begin
			stall_errors = stall_errors + 1;
			$error("instr_valid raised while stall is high");
		end

	// Restore and rename never share a cycle
	assert property (@(posedge clk) disable iff (rst) !(instr_valid && restore))
		else begin
			overlap_errors = overlap_errors + 1;
			$error("instr_valid and restore high in the same cycle");
		end

	// Exactly one output cycle per strobe
	assert property (@(posedge clk) disable iff (rst) instr_valid |=> out_valid)
		else begin
			strobe_errors = strobe_errors + 1;
			$error("out_valid missing after instr_valid");
		end

	assert property (@(posedge clk) disable iff (rst) !instr_valid |=> !out_valid)
		else begin
			strobe_errors = strobe_errors + 1;
			$error("out_valid high without a preceding instr_valid");
		end

	// Only the upper half is free until something is committed
	assert property (@(posedge clk) disable iff (rst)
			(out_valid && out_dst_used && !committed) |-> (out_prd >= preg_t'(AREGS)))
		else begin
			low_prd_errors = low_prd_errors + 1;
			$error("out_prd below the reset free range before any commit");
		end

endmodule

bind rename_unit rename_unit_sva rename_unit_sva_inst (
	.clk         (clk),
	.rst         (rst),
	.instr_valid (instr_valid),
	.restore     (restore),
	.cmt_valid   (cmt_valid),
	.stall       (stall),
	.out_valid   (out_valid),
	.out_dst_used(out_dst_used),
	.out_prd     (out_prd)
);

`default_nettype wire

// File: bench/rename_unit_tb.sv
// ============================================================
// Rename unit testbench
// Reads the case file, drives one line per cycle on the
// falling edge and reports the error counts at the end
// ============================================================
`timescale 1ns/100ps
`default_nettype none

module rename_unit_tb;
	import rename_pkg::*;

	localparam int CHECKPOINTS = 8;
	localparam int CPW = $clog2(CHECKPOINTS);
	localparam int PERIOD = 40;
	localparam int MAX_CASES = 128;
	localparam int NFIELDS = 18;

	// DUT inputs
	logic           clk;
	logic           rst;
	logic           instr_valid;
	logic [15:0]    instr;
	logic           cmt_valid;
	preg_t          cmt_old_preg;
	logic           cmt_branch;
	logic           restore;
	logic [CPW-1:0] restore_cp;

	// DUT outputs
	logic           stall;
	logic           out_valid;
	op_e            out_op;
	preg_t          out_prd;
	preg_t          out_old_prd;
	preg_t          out_ps1;
	preg_t          out_ps2;
	logic           out_dst_used;
	logic           out_src1_used;
	logic           out_src2_used;
	logic [CPW-1:0] out_cp;

	// Expected values handed to the checker
	logic           check_on;
	logic           exp_valid;
	logic [3:0]     exp_op;
	preg_t          exp_prd;
	preg_t          exp_old_prd;
	preg_t          exp_ps1;
	preg_t          exp_ps2;
	logic           exp_dst_used;
	logic           exp_src1_used;
	logic           exp_src2_used;
	logic [CPW-1:0] exp_cp;
	logic           exp_stall;

	// Case table, columns as in the case file
	logic [15:0] cases [MAX_CASES][NFIELDS];
	int          num_cases = 0;
	int          format_errors = 0;
	logic        cases_loaded = 1'b0;

	int value_errors;
	int strobe_errors;
	int assert_errors;

	rename_unit #(
		.CHECKPOINTS(CHECKPOINTS)
	) rename_unit_inst (
		.clk          (clk),
		.rst          (rst),
		.instr_valid  (instr_valid),
		.instr        (instr),
		.cmt_valid    (cmt_valid),
		.cmt_old_preg (cmt_old_preg),
		.cmt_branch   (cmt_branch),
		.restore      (restore),
		.restore_cp   (restore_cp),
		.stall        (stall),
		.out_valid    (out_valid),
		.out_op       (out_op),
		.out_prd      (out_prd),
		.out_old_prd  (out_old_prd),
		.out_ps1      (out_ps1),
		.out_ps2      (out_ps2),
		.out_dst_used (out_dst_used),
		.out_src1_used(out_src1_used),
		.out_src2_used(out_src2_used),
		.out_cp       (out_cp)
	);

	rename_checker #(
		.CHECKPOINTS(CHECKPOINTS)
	) rename_checker_inst (
		.clk          (clk),
		.rst          (rst),
		.check_on     (check_on),
		.exp_valid    (exp_valid),
		.exp_op       (exp_op),
		.exp_prd      (exp_prd),
		.exp_old_prd  (exp_old_prd),
		.exp_ps1      (exp_ps1),
		.exp_ps2      (exp_ps2),
		.exp_dst_used (exp_dst_used),
		.exp_src1_used(exp_src1_used),
		.exp_src2_used(exp_src2_used),
		.exp_cp       (exp_cp),
		.exp_stall    (exp_stall),
		.stall        (stall),
		.out_valid    (out_valid),
		.out_op       (out_op),
		.out_prd      (out_prd),
		.out_old_prd  (out_old_prd),
		.out_ps1      (out_ps1),
		.out_ps2      (out_ps2),
		.out_dst_used (out_dst_used),
		.out_src1_used(out_src1_used),
		.out_src2_used(out_src2_used),
		.out_cp       (out_cp),
		.value_errors (value_errors),
		.strobe_errors(strobe_errors)
	);

	// ============================================================
	// Clock and case file
	// ============================================================
	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// Comment lines start with #, blank lines are skipped
	task automatic load_cases();
		int                fd;
		int                got;
		string             line;
		logic [15:0]       vals [NFIELDS];
		fd = $fopen("bench/rename_cases.txt", "r");
		if (fd == 0) begin
			num_cases = -1;
		end else begin
			while ($fgets(line, fd) != 0) begin
				if (line.len() > 1 && line.getc(0) != 8'h23 && num_cases < MAX_CASES) begin
					got = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
						vals[0], vals[1], vals[2], vals[3], vals[4], vals[5],
						vals[6], vals[7], vals[8], vals[9], vals[10], vals[11],
						vals[12], vals[13], vals[14], vals[15], vals[16], vals[17]);
					if (got == NFIELDS) begin
						cases[num_cases] = vals;
						num_cases = num_cases + 1;
					end else begin
						format_errors = format_errors + 1;
						$display("Case line has %0d fields instead of %0d: %s", got, NFIELDS, line);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// Inputs for this cycle, expectations for the next
	task automatic apply_case(input int k);
		instr_valid   = cases[k][0][0];
		instr         = cases[k][1];
		cmt_valid     = cases[k][2][0];
		cmt_old_preg  = preg_t'(cases[k][3]);
		restore       = cases[k][4][0];
		restore_cp    = cases[k][5][CPW-1:0];
		cmt_branch    = cases[k][6][0];
		check_on      = 1'b1;
		exp_valid     = cases[k][7][0];
		exp_op        = cases[k][8][3:0];
		exp_prd       = preg_t'(cases[k][9]);
		exp_old_prd   = preg_t'(cases[k][10]);
		exp_ps1       = preg_t'(cases[k][11]);
		exp_ps2       = preg_t'(cases[k][12]);
		exp_dst_used  = cases[k][13][0];
		exp_src1_used = cases[k][14][0];
		exp_src2_used = cases[k][15][0];
		exp_cp        = cases[k][16][CPW-1:0];
		exp_stall     = cases[k][17][0];
	endtask

	task automatic drive_idle();
		instr_valid = 1'b0;
		instr       = '0;
		cmt_valid   = 1'b0;
		cmt_branch  = 1'b0;
		restore     = 1'b0;
		restore_cp  = '0;
		check_on    = 1'b0;
		exp_valid   = 1'b0;
	endtask

	// ============================================================
	// Main sequence
	// ============================================================
	initial begin : main
		int total;
		rst           = 1'b1;
		cmt_old_preg  = '0;
		exp_op        = '0;
		exp_prd       = '0;
		exp_old_prd   = '0;
		exp_ps1       = '0;
		exp_ps2       = '0;
		exp_dst_used  = 1'b0;
		exp_src1_used = 1'b0;
		exp_src2_used = 1'b0;
		exp_cp        = '0;
		exp_stall     = 1'b0;
		drive_idle();
		load_cases();
		cases_loaded = 1'b1;
		if (num_cases <= 0) begin
			$display("No usable stimulus found in bench/rename_cases.txt");
			$display("Test failed");
			$finish;
		end else begin
			// Reset held for three rising edges
			repeat (3) @(posedge clk);
			@(negedge clk);
			rst = 1'b0;
			for (int k = 0; k < num_cases; k++) begin
				apply_case(k);
				@(negedge clk);
			end
			drive_idle();
			// Let the last expectation drain through the checker
			repeat (2) @(negedge clk);
			assert_errors = rename_unit_inst.rename_unit_sva_inst.fail_count;
			total = value_errors + strobe_errors + assert_errors + format_errors;
			$display("Errors: %0d value, %0d strobe, %0d assertion, %0d format, %0d total",
				value_errors, strobe_errors, assert_errors, format_errors, total);
			if (total == 0) begin
				$display("Test passed");
			end else begin
				$display("Test failed");
			end
			$finish;
		end
	end

	// Bound on run time from the case count
	initial begin : watchdog
		wait (cases_loaded);
		#((num_cases + 20) * PERIOD);
		$display("Watchdog expired after %0d cycles, the run did not finish", num_cases + 20);
		$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: rename_unit.f
src/rename_pkg.sv
src/instr_decoder.sv
src/checkpoint_ram.sv
src/reg_alias_table.sv
src/free_list.sv
src/rename_result.sv
src/rename_unit.sv
bench/rename_checker.sv
bench/rename_unit_sva.sv
bench/rename_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the rename unit testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
	--top-module rename_unit_tb \
	-f rename_unit.f \
	-o rename_sim

# Let the run go on after an assertion error so the testbench reports it
if ! ./obj_dir/rename_sim +verilator+error+limit+1000 > sim.log 2>&1; then
	cat sim.log
	echo "Simulation exited abnormally"
	exit 1
fi

cat sim.log

if grep -q "Test failed" sim.log; then
	exit 1
fi
exit 0

// File: bench/rename_cases.txt
# inputs:   instr_valid instr cmt_valid cmt_old_preg restore restore_cp cmt_branch
# expected next cycle: out_valid op prd old_prd ps1 ps2 dst_used src1_used src2_used cp stall
1 1123 0 00 0 0 0   1 1 10 01 02 03 1 1 1 0 0
1 2210 0 00 0 0 0   1 2 11 02 10 00 1 1 0 0 0
1 3120 0 00 0 0 0   1 3 12 10 11 00 1 1 0 0 0
1 4012 0 00 0 0 0   1 4 00 00 12 11 0 1 1 0 0
1 0000 0 00 0 0 0   1 0 00 00 00 00 0 0 0 0 0
1 1313 0 00 0 0 0   1 1 13 03 12 03 1 1 1 0 0
0 0000 1 10 0 0 0   0 0 00 00 00 00 0 0 0 0 0
1 1445 0 00 0 0 0   1 1 10 04 04 05 1 1 1 0 0
1 5012 0 00 0 0 0   1 5 00 00 12 11 0 1 1 0 0
1 1134 0 00 0 0 0   1 1 14 12 13 10 1 1 1 1 0
1 3210 0 00 0 0 0   1 3 15 11 14 00 1 1 0 1 0
0 0000 0 00 1 0 0   0 0 00 00 00 00 0 0 0 0 1
0 0000 0 00 0 0 0   0 0 00 00 00 00 0 0 0 0 0
1 1512 0 00 0 0 0   1 1 14 05 12 11 1 1 1 1 0
0 0000 0 00 0 0 1   0 0 00 00 00 00 0 0 0 0 0
1 5045 0 00 0 0 0   1 5 00 00 10 14 0 1 1 1 0
1 5045 0 00 0 0 0   1 5 00 00 10 14 0 1 1 2 0
1 5045 0 00 0 0 0   1 5 00 00 10 14 0 1 1 3 0
1 5045 0 00 0 0 0   1 5 00 00 10 14 0 1 1 4 0
1 5045 0 00 0 0 0   1 5 00 00 10 14 0 1 1 5 0
1 5045 0 00 0 0 0   1 5 00 00 10 14 0 1 1 6 0
1 5045 0 00 0 0 0   1 5 00 00 10 14 0 1 1 7 0
1 5045 0 00 0 0 0   1 5 00 00 10 14 0 1 1 0 1
0 0000 0 00 0 0 1   0 0 00 00 00 00 0 0 0 0 0
1 2660 0 00 0 0 0   1 2 15 06 06 00 1 1 0 1 0
1 2660 0 00 0 0 0   1 2 16 15 15 00 1 1 0 1 0
1 2660 0 00 0 0 0   1 2 17 16 16 00 1 1 0 1 0
1 2660 0 00 0 0 0   1 2 18 17 17 00 1 1 0 1 0
1 2660 0 00 0 0 0   1 2 19 18 18 00 1 1 0 1 0
1 2660 0 00 0 0 0   1 2 1a 19 19 00 1 1 0 1 0
1 2660 0 00 0 0 0   1 2 1b 1a 1a 00 1 1 0 1 0
1 2660 0 00 0 0 0   1 2 1c 1b 1b 00 1 1 0 1 0
1 2660 0 00 0 0 0   1 2 1d 1c 1c 00 1 1 0 1 0
1 2660 0 00 0 0 0   1 2 1e 1d 1d 00 1 1 0 1 0
1 2660 0 00 0 0 0   1 2 1f 1e 1e 00 1 1 0 1 1
0 0000 1 06 0 0 0   0 0 00 00 00 00 0 0 0 0 0
1 2660 0 00 0 0 0   1 2 06 1f 1f 00 1 1 0 1 1
0 0000 1 1e 0 0 0   0 0 00 00 00 00 0 0 0 0 0
1 0000 0 00 0 0 0   1 0 00 00 00 00 0 0 0 1 0
